//--- Makefile
# Verilator flow for the USB OUT protocol engine

VERILATOR  ?= verilator
TOP        ?= tb_usb_out_pe
FILELIST   ?= usb_out_pe.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, a run without a pass line counts as failed
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_usb_out_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_pe_macros.svh"

module tb_usb_out_pe
  import usb_pid_pkg::*;
  import usb_out_pe_pkg::*;
();

  localparam int        NumXacts   = 200;
  // Worst transaction is about 100 cycles with the longest packet
  localparam int        CycleLimit = NumXacts * 100;
  localparam int        NumEps     = `USB_OUT_NUM_EPS;
  localparam int        MaxAddr    = `USB_OUT_MAX_PKT_BYTES - 1;
  localparam dev_addr_t DevAddr    = 7'h2a;

  logic     clk_48mhz;
  logic     rst_n;
  logic     link_reset;
  rx_pkt_t  rx;
  rx_data_t rx_data;
  ep_cfg_t  ep_cfg;
  tog_wr_t  tog_wr;
  ep_put_t  out_ep;
  ep_mask_t out_setup;
  ep_mask_t out_toggle;
  tx_req_t  tx;
  logic     event_datatog;

  integer seed = 7;
  int     cycles = 0;

  // Reference model
  ep_mask_t model_tog;
  ep_mask_t model_setup;
  byte_t    pkt_bytes[$];
  byte_t    exp_bytes[$];
  logic     exp_full;
  ep_num_t  exp_ep;

  // Activity seen during the current transaction
  int       put_cnt;
  int       tx_cnt;
  int       acked_cnt;
  int       rollback_cnt;
  int       event_cnt;
  int       newpkt_cnt;
  usb_pid_e tx_pid;

  usb_out_pe usb_out_pe_i (
    .clk_48mhz_i         (clk_48mhz),
    .rst_ni              (rst_n),
    .link_reset_i        (link_reset),
    .dev_addr_i          (DevAddr),
    .rx_i                (rx),
    .rx_data_i           (rx_data),
    .ep_cfg_i            (ep_cfg),
    .tog_wr_i            (tog_wr),
    .out_ep_o            (out_ep),
    .out_ep_setup_o      (out_setup),
    .out_data_toggle_o   (out_toggle),
    .tx_o                (tx),
    .event_datatog_out_o (event_datatog)
  );

  bind usb_out_pe tb_usb_out_pe_assertions u_assertions (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .tx_start_i  (tx_o.start),
    .acked_i     (out_ep_o.acked),
    .rollback_i  (out_ep_o.rollback),
    .newpkt_i    (out_ep_o.newpkt)
  );

  initial clk_48mhz = 1'b0;
  always #4 clk_48mhz = ~clk_48mhz;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Run limit
  always @(posedge clk_48mhz) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      report_error($sformatf("Run did not finish within %0d cycles", CycleLimit));
    end
  end

  // A full endpoint freezes the put address after its first byte
  function automatic int put_addr_for(input int idx, input logic full);
    if (full) begin
      return (idx == 0) ? 0 : 1;
    end
    return (idx > MaxAddr) ? MaxAddr : idx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Output monitor sampling at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      if (out_ep.data_put) begin
        assert (put_cnt < exp_bytes.size())
          else report_error("Data byte forwarded when none was expected");
        check_eq("out_ep_o.data", out_ep.data, exp_bytes[put_cnt]);
        check_eq("out_ep_o.put_addr", out_ep.put_addr, put_addr_for(put_cnt, exp_full));
        put_cnt++;
      end
      if (tx.start) begin
        tx_cnt++;
        tx_pid = tx.pid;
      end
      if (out_ep.acked) acked_cnt++;
      if (out_ep.rollback) rollback_cnt++;
      if (event_datatog) event_cnt++;
      if (out_ep.newpkt) begin
        newpkt_cnt++;
        check_eq("out_ep_o.current", out_ep.current, exp_ep);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Step past the edge and drop all strobes
  task automatic next_cycle();
    @(posedge clk_48mhz);
    #1;
    rx.pkt_start = 1'b0;
    rx.pkt_end   = 1'b0;
    rx_data.put  = 1'b0;
    tog_wr.we    = 1'b0;
    link_reset   = 1'b0;
  endtask

  task automatic send_token(input usb_pid_e pid, input dev_addr_t addr, input ep_num_t endp);
    next_cycle();
    rx.pkt_start = 1'b1;
    repeat (3) next_cycle();
    rx.pkt_end = 1'b1;
    rx.valid   = 1'b1;
    rx.pid     = pid;
    rx.addr    = addr;
    rx.endp    = endp;
  endtask

  // Payload from pkt_bytes with random idle cycles between bytes
  task automatic send_data(input logic odd, input logic valid);
    next_cycle();
    rx.pkt_start = 1'b1;
    foreach (pkt_bytes[i]) begin
      next_cycle();
      rx_data.put  = 1'b1;
      rx_data.data = pkt_bytes[i];
      if ($random(seed) & 1) next_cycle();
    end
    next_cycle();
    rx.pkt_end = 1'b1;
    rx.valid   = valid;
    rx.pid     = odd ? UsbPidData1 : UsbPidData0;
  endtask

  task automatic wait_handshake();
    int n;
    n = 0;
    while ((tx_cnt == 0) && (n < 4)) begin
      next_cycle();
      n++;
    end
    assert (tx_cnt != 0) else report_error("No handshake sent after the data packet");
  endtask

  task automatic write_toggles();
    next_cycle();
    tog_wr.we     = 1'b1;
    tog_wr.status = ep_mask_t'($random(seed));
    tog_wr.mask   = ep_mask_t'($random(seed));
    // Each masked endpoint takes the written value
    for (int i = 0; i < NumEps; i++) begin
      if (tog_wr.mask[i]) begin
        model_tog[i] = tog_wr.status[i];
      end
    end
    next_cycle();
    check_eq("out_data_toggle_o", out_toggle, model_tog);
  endtask

  // Bus reset clears toggles and keeps the SETUP flags
  task automatic pulse_link_reset();
    next_cycle();
    link_reset = 1'b1;
    model_tog  = '0;
    next_cycle();
    check_eq("out_data_toggle_o", out_toggle, model_tog);
    check_eq("out_ep_setup_o", out_setup, model_setup);
  endtask

  task automatic run_xact();
    logic     is_setup;
    logic     addr_ok;
    logic     active;
    logic     starts;
    logic     send_pkt;
    logic     pkt_valid;
    logic     pkt_odd;
    logic     exp_tx;
    logic     exp_acked;
    logic     exp_rollback;
    logic     exp_event;
    logic     flip;
    usb_pid_e exp_pid;
    ep_num_t  endp;
    ep_idx_t  idx;
    int       nbytes;
    int       r;

    // Mostly enabled, sometimes full, rarely stalled
    next_cycle();
    ep_cfg.enabled = ep_mask_t'($random(seed) | $random(seed));
    ep_cfg.control = ep_mask_t'($random(seed));
    ep_cfg.full    = ep_mask_t'($random(seed) & $random(seed));
    ep_cfg.stall   = ep_mask_t'($random(seed) & $random(seed) & $random(seed));

    is_setup  = ($unsigned($random(seed)) % 10) < 3;
    addr_ok   = ($unsigned($random(seed)) % 10) != 0;
    r         = $unsigned($random(seed)) % 16;
    // A quarter of the tokens name an endpoint that does not exist
    endp      = ep_num_t'((r < 12) ? (r % NumEps) : r);
    send_pkt  = ($unsigned($random(seed)) % 20) != 0;
    pkt_valid = ($unsigned($random(seed)) % 10) != 0;
    nbytes    = $unsigned($random(seed)) % 41;
    idx       = ep_idx_t'(endp);

    // Token side effects on the model
    active = addr_ok && (endp < NumEps) && ep_cfg.enabled[idx];
    if (active && is_setup) begin
      model_tog[idx]   = 1'b0;
      model_setup[idx] = 1'b1;
    end else if (active) begin
      model_setup[idx] = 1'b0;
    end
    starts  = active && (!is_setup || ep_cfg.control[idx]);
    pkt_odd = model_tog[idx] ^ (($unsigned($random(seed)) % 5) == 0);

    pkt_bytes.delete();
    repeat (nbytes) pkt_bytes.push_back(byte_t'($random(seed)));
    exp_bytes.delete();
    if (starts && send_pkt) exp_bytes = pkt_bytes;
    exp_full = ep_cfg.full[idx];
    exp_ep   = endp;

    // Expected handshake and termination
    exp_tx       = 1'b0;
    exp_pid      = UsbPidAck;
    exp_acked    = 1'b0;
    exp_rollback = 1'b0;
    exp_event    = 1'b0;
    flip         = 1'b0;
    if (starts && send_pkt) begin
      if (pkt_valid && (pkt_odd != model_tog[idx]) && !ep_cfg.stall[idx]) begin
        // Repeated packet is acked and thrown away
        exp_tx       = 1'b1;
        exp_rollback = 1'b1;
        exp_event    = 1'b1;
      end else if (!pkt_valid) begin
        exp_rollback = 1'b1;
      end else if (is_setup) begin
        exp_rollback = ep_cfg.full[idx];
        exp_tx       = !ep_cfg.full[idx];
        exp_acked    = !ep_cfg.full[idx];
        flip         = !ep_cfg.full[idx];
      end else if (ep_cfg.stall[idx]) begin
        exp_tx  = 1'b1;
        exp_pid = UsbPidStall;
      end else if (ep_cfg.full[idx]) begin
        exp_tx       = 1'b1;
        exp_pid      = UsbPidNak;
        exp_rollback = 1'b1;
      end else begin
        exp_tx    = 1'b1;
        exp_acked = 1'b1;
        flip      = 1'b1;
      end
    end

    put_cnt      = 0;
    tx_cnt       = 0;
    acked_cnt    = 0;
    rollback_cnt = 0;
    event_cnt    = 0;
    newpkt_cnt   = 0;

    send_token(is_setup ? UsbPidSetup : UsbPidOut,
               addr_ok ? DevAddr : DevAddr ^ dev_addr_t'(1 + $unsigned($random(seed)) % 127),
               endp);
    if (send_pkt) begin
      repeat ($unsigned($random(seed)) % 8) next_cycle();
      send_data(pkt_odd, pkt_valid);
      if (exp_tx) wait_handshake();
    end else begin
      // Without a data packet the engine has to give up by itself
      repeat (`USB_OUT_ACK_TIMEOUT + 12) next_cycle();
    end
    repeat (3) next_cycle();

    if (flip) model_tog[idx] = ~model_tog[idx];
    check_eq("out_ep_o.newpkt count", newpkt_cnt, starts);
    check_eq("out_ep_o.data_put count", put_cnt, exp_bytes.size());
    check_eq("tx_o.start count", tx_cnt, exp_tx);
    if (exp_tx) check_eq("tx_o.pid", tx_pid, exp_pid);
    check_eq("out_ep_o.acked count", acked_cnt, exp_acked);
    check_eq("out_ep_o.rollback count", rollback_cnt, exp_rollback);
    check_eq("event_datatog_out_o count", event_cnt, exp_event);
    check_eq("out_data_toggle_o", out_toggle, model_tog);
    check_eq("out_ep_setup_o", out_setup, model_setup);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int r;

    rst_n       = 1'b0;
    link_reset  = 1'b0;
    rx          = '0;
    rx_data     = '0;
    ep_cfg      = '0;
    tog_wr      = '0;
    model_tog   = '0;
    model_setup = '0;
    repeat (2) @(posedge clk_48mhz);
    #1;
    rst_n = 1'b1;

    // Clean state out of reset
    next_cycle();
    check_eq("out_data_toggle_o", out_toggle, model_tog);
    check_eq("out_ep_setup_o", out_setup, model_setup);

    for (int i = 0; i < NumXacts; i++) begin
      r = $unsigned($random(seed)) % 20;
      if (r == 0) begin
        pulse_link_reset();
      end else if (r < 3) begin
        write_toggles();
      end
      run_xact();
    end

    if (usb_out_pe_i.u_assertions.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_error("Bound assertions on the DUT reported failures");
    end
  end

endmodule

`default_nettype wire

//--- tb_usb_out_pe_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_out_pe_assertions (
  input logic clk_48mhz_i,
  input logic rst_ni,
  input logic tx_start_i,
  input logic acked_i,
  input logic rollback_i,
  input logic newpkt_i
);

  // Failure count that the testbench reads at the end of the run
  int unsigned fail_cnt = 0;

  // Good termination always goes out with a handshake
  tx_outcome_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    acked_i |-> tx_start_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("acked without a handshake");
    end

  // Good and bad termination exclude each other
  outcome_onehot_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(acked_i && rollback_i))
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("acked and rollback high in the same cycle");
    end

  // newpkt marks one transaction start
  newpkt_pulse_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    newpkt_i |=> !newpkt_i)
    else begin
      fail_cnt <= fail_cnt + 1;
      $error("newpkt held longer than one cycle");
    end

endmodule

`default_nettype wire

//--- usb_out_data_path.sv
`timescale 1ns/1ps
`default_nettype none

module usb_out_data_path
  import usb_out_pe_pkg::*;
(
  input  logic        clk_48mhz_i,
  input  logic        rst_ni,
  input  rx_data_t    rx_data_i,
  input  xact_state_e state_i,
  input  ep_idx_t     cur_idx_i,
  input  ep_cfg_t     ep_cfg_i,
  output ep_put_t     put_o,
  output logic        nak_o
);

  byte_t     data_q;
  logic      put_q;
  logic      nak_q;
  pkt_addr_t addr_q;
  logic      inc_addr;

  // Last received byte
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_i.put) begin
      data_q <= rx_data_i.data;
    end
  end

  // Put strobe lines up with the latched byte
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_q <= 1'b0;
    end else begin
      put_q <= (state_i == DataStart) && rx_data_i.put;
    end
  end

  // Any byte arriving while the endpoint is full forces a NAK
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if ((state_i == Idle) || (state_i == RcvdToken)) begin
      nak_q <= 1'b0;
    end else if (put_q && ep_cfg_i.full[cur_idx_i]) begin
      nak_q <= 1'b1;
    end
  end

  // Advance after each put, hold at the last slot
  // Frozen once the packet is going to be NAKed
  assign inc_addr = put_q && !nak_q && !(&addr_q);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (state_i == RcvdToken) begin
      addr_q <= '0;
    end else if ((state_i == DataStart) && inc_addr) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  always_comb begin
    put_o          = '0;
    put_o.data_put = put_q;
    put_o.put_addr = addr_q;
    put_o.data     = data_q;
  end

  assign nak_o = nak_q;

endmodule

`default_nettype wire

//--- usb_out_ep_state.sv
`timescale 1ns/1ps
`default_nettype none

module usb_out_ep_state
  import usb_out_pe_pkg::*;
(
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  token_evt_t tok_i,
  input  ep_idx_t    cur_idx_i,
  input  logic       new_pkt_end_i,
  input  tog_wr_t    tog_wr_i,
  output ep_mask_t   data_toggle_o,
  output ep_mask_t   setup_o
);

  ep_mask_t toggle_q, toggle_d;
  ep_mask_t setup_q, setup_d;

  always_comb begin
    toggle_d = toggle_q;
    setup_d  = setup_q;

    // SETUP restarts the control sequence at DATA0
    if (tok_i.setup_tok && tok_i.ep_active) begin
      toggle_d[tok_i.ep_idx] = 1'b0;
      setup_d[tok_i.ep_idx]  = 1'b1;
    end else if (tok_i.out_tok && tok_i.ep_active) begin
      setup_d[tok_i.ep_idx] = 1'b0;
    end

    // Accepted packet flips the toggle
    if (new_pkt_end_i) begin
      toggle_d[cur_idx_i] = ~toggle_q[cur_idx_i];
    end

    // Software overrides only the masked bits
    if (tog_wr_i.we) begin
      toggle_d = (toggle_d & ~tog_wr_i.mask) | (tog_wr_i.status & tog_wr_i.mask);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
      setup_q  <= '0;
    end else begin
      // Bus reset puts every endpoint back to DATA0
      toggle_q <= link_reset_i ? '0 : toggle_d;
      setup_q  <= setup_d;
    end
  end

  assign data_toggle_o = toggle_q;
  assign setup_o       = setup_q;

endmodule

`default_nettype wire

//--- usb_out_pe.f
+incdir+.
usb_pid_pkg.sv
usb_out_pe_pkg.sv
usb_out_token_decode.sv
usb_out_xact_fsm.sv
usb_out_ep_state.sv
usb_out_data_path.sv
usb_out_pe.sv
tb_usb_out_pe_assertions.sv
tb_usb_out_pe.sv

//--- usb_out_pe.sv
`timescale 1ns/1ps
`default_nettype none

module usb_out_pe
  import usb_out_pe_pkg::*;
(
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  dev_addr_t dev_addr_i,
  input  rx_pkt_t   rx_i,
  input  rx_data_t  rx_data_i,
  input  ep_cfg_t   ep_cfg_i,
  input  tog_wr_t   tog_wr_i,
  output ep_put_t   out_ep_o,
  output ep_mask_t  out_ep_setup_o,
  output ep_mask_t  out_data_toggle_o,
  output tx_req_t   tx_o,
  output logic      event_datatog_out_o
);

  token_evt_t  tok;
  xact_state_e state;
  ep_idx_t     cur_idx;
  ep_put_t     xact_put;
  ep_put_t     data_put;
  ep_mask_t    data_toggle;
  logic        new_pkt_end;
  logic        nak;

  //////////////////////////////////////////////////////////////////////
  // Packet decode
  //////////////////////////////////////////////////////////////////////

  usb_out_token_decode u_token_decode (
    .rx_i       (rx_i),
    .dev_addr_i (dev_addr_i),
    .ep_cfg_i   (ep_cfg_i),
    .tok_o      (tok)
  );

  //////////////////////////////////////////////////////////////////////
  // Transaction control
  //////////////////////////////////////////////////////////////////////

  usb_out_xact_fsm u_xact_fsm (
    .clk_48mhz_i         (clk_48mhz_i),
    .rst_ni              (rst_ni),
    .link_reset_i        (link_reset_i),
    .rx_i                (rx_i),
    .tok_i               (tok),
    .ep_cfg_i            (ep_cfg_i),
    .data_toggle_i       (data_toggle),
    .nak_i               (nak),
    .state_o             (state),
    .cur_idx_o           (cur_idx),
    .xact_o              (xact_put),
    .new_pkt_end_o       (new_pkt_end),
    .tx_o                (tx_o),
    .event_datatog_out_o (event_datatog_out_o)
  );

  // Toggles and SETUP flags per endpoint
  usb_out_ep_state u_ep_state (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .tok_i         (tok),
    .cur_idx_i     (cur_idx),
    .new_pkt_end_i (new_pkt_end),
    .tog_wr_i      (tog_wr_i),
    .data_toggle_o (data_toggle),
    .setup_o       (out_ep_setup_o)
  );

  // Byte forwarding to the endpoint
  usb_out_data_path u_data_path (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .rx_data_i   (rx_data_i),
    .state_i     (state),
    .cur_idx_i   (cur_idx),
    .ep_cfg_i    (ep_cfg_i),
    .put_o       (data_put),
    .nak_o       (nak)
  );

  // Control fields from the FSM, payload fields from the data path
  assign out_ep_o = '{
    current:  xact_put.current,
    newpkt:   xact_put.newpkt,
    data_put: data_put.data_put,
    put_addr: data_put.put_addr,
    data:     data_put.data,
    acked:    xact_put.acked,
    rollback: xact_put.rollback
  };

  assign out_data_toggle_o = data_toggle;

endmodule

`default_nettype wire

//--- usb_out_pe_macros.svh
`ifndef USB_OUT_PE_MACROS_SVH
`define USB_OUT_PE_MACROS_SVH

// Build-time sizing of the OUT protocol engine

// Number of OUT endpoints that exist in hardware
`define USB_OUT_NUM_EPS 4

// Largest data payload accepted per packet, in bytes
`define USB_OUT_MAX_PKT_BYTES 32

// Wait for the host data packet after a token
// 17 bit times at 4 clocks per bit on the 48 MHz clock
// SOP delay on both packets cancels out
`define USB_OUT_ACK_TIMEOUT 68

`endif

//--- usb_out_pe_pkg.sv
`default_nettype none

`include "usb_out_pe_macros.svh"

//////////////////////////////////////////////////////////////////////
// Types of the OUT protocol engine
//////////////////////////////////////////////////////////////////////

package usb_out_pe_pkg;
  import usb_pid_pkg::*;

  // Widths with a meaning
  typedef logic [3:0]                                     ep_num_t;
  typedef logic [$clog2(`USB_OUT_NUM_EPS)-1:0]            ep_idx_t;
  typedef logic [`USB_OUT_NUM_EPS-1:0]                    ep_mask_t;
  typedef logic [$clog2(`USB_OUT_MAX_PKT_BYTES)-1:0]      pkt_addr_t;
  typedef logic [6:0]                                     dev_addr_t;
  typedef logic [7:0]                                     byte_t;
  typedef logic [$clog2(`USB_OUT_ACK_TIMEOUT)-1:0]        timeout_cnt_t;

  // Packet framing from the receiver
  // pid, addr and endp hold until the next packet
  typedef struct packed {
    logic      pkt_start;
    logic      pkt_end;
    logic      valid;
    logic [3:0] pid;
    dev_addr_t addr;
    ep_num_t   endp;
  } rx_pkt_t;

  // Byte stream from the receiver
  typedef struct packed {
    logic  put;
    byte_t data;
  } rx_data_t;

  // Endpoint configuration, one bit per endpoint
  typedef struct packed {
    ep_mask_t enabled;
    ep_mask_t control;
    ep_mask_t full;
    ep_mask_t stall;
  } ep_cfg_t;

  // Masked data toggle write from software
  typedef struct packed {
    logic     we;
    ep_mask_t status;
    ep_mask_t mask;
  } tog_wr_t;

  // Decoded packet, valid in the packet end cycle
  typedef struct packed {
    logic    out_tok;
    logic    setup_tok;
    logic    data_pkt;
    logic    bad_pkt;
    logic    pid_odd;
    logic    ep_active;
    logic    ep_control;
    ep_idx_t ep_idx;
    ep_num_t ep_num;
  } token_evt_t;

  // Endpoint side interface
  typedef struct packed {
    ep_num_t   current;
    logic      newpkt;
    logic      data_put;
    pkt_addr_t put_addr;
    byte_t     data;
    logic      acked;
    logic      rollback;
  } ep_put_t;

  // Handshake request to the transmitter
  typedef struct packed {
    logic     start;
    usb_pid_e pid;
  } tx_req_t;

  // OUT and SETUP transaction phases
  typedef enum logic [1:0] {
    Idle,
    RcvdToken,
    DataStart,
    DataEnd
  } xact_state_e;

endpackage

`default_nettype wire

//--- usb_out_token_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_pe_macros.svh"

module usb_out_token_decode
  import usb_pid_pkg::*;
  import usb_out_pe_pkg::*;
(
  input  rx_pkt_t    rx_i,
  input  dev_addr_t  dev_addr_i,
  input  ep_cfg_t    ep_cfg_i,
  output token_evt_t tok_o
);

  usb_pid_type_e pid_type;
  logic          token_rcvd;
  logic          is_data_pid;
  logic          ep_in_hw;
  ep_idx_t       ep_idx;

  // PID type from the low two bits
  assign pid_type = usb_pid_type_e'(rx_i.pid[1:0]);

  // Good token addressed to this device
  assign token_rcvd = rx_i.pkt_end && rx_i.valid &&
                      (pid_type == UsbPidTypeToken) &&
                      (rx_i.addr == dev_addr_i);

  // DATA0 or DATA1
  assign is_data_pid = (rx_i.pid == UsbPidData0) || (rx_i.pid == UsbPidData1);

  // Endpoint number must map onto an implemented endpoint
  assign ep_in_hw = ({1'b0, rx_i.endp} < `USB_OUT_NUM_EPS);
  // Unimplemented numbers fold to index zero, gated by ep_in_hw below
  assign ep_idx   = ep_in_hw ? ep_idx_t'(rx_i.endp) : '0;

  always_comb begin
    tok_o = '0;

    // Split tokens by kind
    tok_o.out_tok   = token_rcvd && (rx_i.pid == UsbPidOut);
    tok_o.setup_tok = token_rcvd && (rx_i.pid == UsbPidSetup);

    // Data packet with good CRC
    tok_o.data_pkt = rx_i.pkt_end && rx_i.valid && is_data_pid;
    // Anything else ending here breaks a transaction
    tok_o.bad_pkt  = rx_i.pkt_end && !(rx_i.valid && is_data_pid);

    // Odd bit of the PID selects DATA1
    tok_o.pid_odd = rx_i.pid[3];

    // Endpoint lookup
    tok_o.ep_idx     = ep_idx;
    tok_o.ep_num     = ep_in_hw ? rx_i.endp : '0;
    tok_o.ep_active  = ep_in_hw && ep_cfg_i.enabled[ep_idx];
    tok_o.ep_control = ep_cfg_i.control[ep_idx];
  end

endmodule

`default_nettype wire

//--- usb_out_xact_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_pe_macros.svh"

module usb_out_xact_fsm
  import usb_pid_pkg::*;
  import usb_out_pe_pkg::*;
(
  input  logic        clk_48mhz_i,
  input  logic        rst_ni,
  input  logic        link_reset_i,
  input  rx_pkt_t     rx_i,
  input  token_evt_t  tok_i,
  input  ep_cfg_t     ep_cfg_i,
  input  ep_mask_t    data_toggle_i,
  input  logic        nak_i,
  output xact_state_e state_o,
  output ep_idx_t     cur_idx_o,
  output ep_put_t     xact_o,
  output logic        new_pkt_end_o,
  output tx_req_t     tx_o,
  output logic        event_datatog_out_o
);

  xact_state_e  state_q, state_d;
  timeout_cnt_t cnt_q, cnt_d;

  // Transaction context captured at the token
  ep_idx_t cur_idx_q;
  ep_num_t cur_num_q;
  logic    setup_q;
  logic    newpkt_q;

  logic xact_start;
  logic tog_mismatch;
  logic ep_stalled;
  logic ep_full;
  logic drop_tog;

  // Status of the endpoint in flight
  assign ep_stalled = ep_cfg_i.stall[cur_idx_q];
  assign ep_full    = ep_cfg_i.full[cur_idx_q];

  // DATA PID odd bit against the expected toggle
  assign tog_mismatch = tok_i.data_pkt && (tok_i.pid_odd != data_toggle_i[cur_idx_q]);

  // Retransmitted packet, host most likely lost our ACK
  // Stalled endpoints skip this and answer STALL later
  assign drop_tog = (state_q == DataStart) && tog_mismatch && !ep_stalled;

  //////////////////////////////////////////////////////////////////////
  // Next state and handshake
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cnt_d         = timeout_cnt_t'(`USB_OUT_ACK_TIMEOUT);
    xact_start    = 1'b0;
    new_pkt_end_o = 1'b0;
    tx_o          = '0;
    xact_o        = '0;

    unique case (state_q)
      Idle: begin
        // SETUP only goes to control endpoints
        if (tok_i.ep_active &&
            (tok_i.out_tok || (tok_i.setup_tok && tok_i.ep_control))) begin
          state_d    = RcvdToken;
          xact_start = 1'b1;
        end
      end

      RcvdToken: begin
        // Bounded wait for the data packet
        cnt_d = cnt_q - 1'b1;
        if (rx_i.pkt_start) begin
          state_d = DataStart;
        end else if (cnt_q == '0) begin
          state_d = Idle;
        end
      end

      DataStart: begin
        if (drop_tog) begin
          state_d         = Idle;
          xact_o.rollback = 1'b1;
          tx_o.start      = 1'b1;
          tx_o.pid        = UsbPidAck;
        end else if (tok_i.bad_pkt) begin
          // Bad CRC or wrong PID, host sees silence
          state_d         = Idle;
          xact_o.rollback = 1'b1;
        end else if (tok_i.data_pkt) begin
          state_d = DataEnd;
        end
      end

      DataEnd: begin
        state_d    = Idle;
        tx_o.start = 1'b1;
        if (setup_q) begin
          // Undeliverable SETUP is dropped without a handshake
          if (nak_i || ep_full) begin
            tx_o.start      = 1'b0;
            xact_o.rollback = 1'b1;
          end else begin
            tx_o.pid      = UsbPidAck;
            new_pkt_end_o = 1'b1;
            xact_o.acked  = 1'b1;
          end
        end else if (ep_stalled) begin
          tx_o.pid = UsbPidStall;
        end else if (nak_i || ep_full) begin
          // Endpoint cannot take the data now
          tx_o.pid        = UsbPidNak;
          xact_o.rollback = 1'b1;
        end else begin
          tx_o.pid      = UsbPidAck;
          new_pkt_end_o = 1'b1;
          xact_o.acked  = 1'b1;
        end
      end

      default: state_d = Idle;
    endcase

    xact_o.current = cur_num_q;
    xact_o.newpkt  = newpkt_q;
  end

  assign event_datatog_out_o = drop_tog;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      cnt_q   <= timeout_cnt_t'(`USB_OUT_ACK_TIMEOUT);
    end else if (link_reset_i) begin
      state_q <= Idle;
      cnt_q   <= timeout_cnt_t'(`USB_OUT_ACK_TIMEOUT);
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Endpoint and kind are latched once per transaction
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newpkt_q  <= 1'b0;
      cur_idx_q <= '0;
      cur_num_q <= '0;
      setup_q   <= 1'b0;
    end else begin
      newpkt_q <= xact_start && !link_reset_i;
      if (xact_start) begin
        cur_idx_q <= tok_i.ep_idx;
        cur_num_q <= tok_i.ep_num;
        setup_q   <= tok_i.setup_tok;
      end
    end
  end

  assign state_o   = state_q;
  assign cur_idx_o = cur_idx_q;

endmodule

`default_nettype wire

//--- usb_pid_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// USB wire protocol constants
//////////////////////////////////////////////////////////////////////

package usb_pid_pkg;

  // Packet identifiers used by the OUT engine
  // Upper nibble on the wire is the complement, checked by the receiver
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // PID type lives in the two low bits
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

endpackage

`default_nettype wire
